/* compile.f */
source/risc5Pkg.sv
source/risc5Decode.sv
source/risc5Multiplier.sv
source/risc5Execute.sv
source/risc5MemLanes.sv
source/risc5Core.sv
sim/risc5Tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= risc5Tb
FILELIST  ?= compile.f
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

test: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/risc5Tb.sv */
`timescale 1ns/1ps
`default_nettype none

module risc5Tb import risc5Pkg::*; ();

  logic        clk = 1'b0;
  logic        rst;
  logic        stallX = 1'b0;
  logic [31:0] inbus, codebus, outbus;
  logic [23:0] adr;
  logic        rd, wr, ben;

  logic [31:0] mem [1024];
  logic [31:0] image [1024];  // Next program, copied into mem during reset
  logic [31:0] snap [1024];
  logic [31:0] prog [$];
  logic [31:0] expQ [$];
  logic        loadReq = 1'b0;
  logic        stallOn = 1'b0;
  int          doneCount = 0;
  int          seed = 40;
  int          errors = 0;
  int          checks = 0;
  int          failedTests = 0;
  int          testNum = 0;

  risc5Core dut_i (
    .clk(clk), .rst(rst), .stallX(stallX), .inbus(inbus), .codebus(codebus),
    .adr(adr), .rd(rd), .wr(wr), .ben(ben), .outbus(outbus)
  );

  always #10 clk = ~clk;

  assign codebus = mem[adr[11:2]];
  assign inbus   = rd ? mem[adr[11:2]] : 32'h0;  // Data only while rd is high

  always @(posedge clk) begin
    if (loadReq) begin
      for (int i = 0; i < 1024; i++) begin
        mem[i[9:0]] <= image[i[9:0]];
      end
    end else if (wr) begin
      if (ben) begin
        mem[adr[11:2]][{adr[1:0], 3'b000} +: 8] <= outbus[{adr[1:0], 3'b000} +: 8];
      end else begin
        mem[adr[11:2]] <= outbus;
      end
      if (adr[11:2] == 10'h3FF) begin
        doneCount <= doneCount + 1;  // Completion store
      end
    end
  end

  always @(posedge clk) begin
    stallX <= stallOn ? (($random(seed) & 3) == 0) : 1'b0;
  end

  always @(posedge clk) begin
    if (!rst && rd && wr) begin
      $display("Bus error: rd and wr high together at %0t", $time);
      errors++;
    end
  end

  function automatic logic [31:0] fillWord(input int i);
    return 32'h6B000000 ^ (i * 32'h00010103);
  endfunction

  function automatic logic [31:0] regIns(input logic q, u, v, input logic [3:0] a, b, op,
                                         input logic [15:0] imm);
    return {1'b0, q, u, v, a, b, op, imm};
  endfunction

  function automatic logic [31:0] memIns(input logic st, by, input logic [3:0] a, b,
                                         input logic [19:0] off);
    return {1'b1, 1'b0, st, by, a, b, off};
  endfunction

  function automatic logic [31:0] brIns(input logic u, v, inv, input logic [2:0] cc,
                                        input logic [21:0] disp);
    return {1'b1, 1'b1, u, v, inv, cc, 2'b00, disp};
  endfunction

  // Expected result of one register instruction
  function automatic logic [31:0] refExec(input logic [3:0] op, input logic q, u, v,
                                          input logic [31:0] bv, cv,
                                          input logic [15:0] imm);
    logic [31:0] c1;
    logic [4:0]  s;
    c1 = q ? {{16{v}}, imm} : cv;
    s  = c1[4:0];
    case (op)
      OpMov:   return q ? (u ? {imm, 16'h0000} : {{16{v}}, imm}) : cv;
      OpLsl:   return bv << s;
      OpAsr:   return $signed(bv) >>> s;
      OpRor:   return (bv >> s) | (bv << (6'd32 - {1'b0, s}));
      OpAnd:   return bv & c1;
      OpAnn:   return bv & ~c1;
      OpIor:   return bv | c1;
      OpXor:   return bv ^ c1;
      OpAdd:   return bv + c1;
      OpSub:   return bv - c1;
      default: return 32'h0;
    endcase
  endfunction

  function automatic logic [63:0] refMul(input logic sgn, input logic [31:0] bv, cv);
    if (sgn) begin
      return $signed({{32{bv[31]}}, bv}) * $signed({{32{cv[31]}}, cv});
    end
    return {32'h0, bv} * {32'h0, cv};
  endfunction

  // Branch decision after SUB bv - cv
  function automatic logic refCond(input logic inv, input logic [2:0] cc,
                                   input logic [31:0] bv, cv);
    logic [32:0] d;
    logic        n, z, c, ov, r;
    d  = {1'b0, bv} - {1'b0, cv};
    n  = d[31];
    z  = (d[31:0] == 32'h0);
    c  = d[32];
    ov = (bv[31] != cv[31]) && (d[31] != bv[31]);
    case (cc)
      3'd0:    r = n;
      3'd1:    r = z;
      3'd2:    r = c;
      3'd3:    r = ov;
      3'd4:    r = c | z;
      3'd5:    r = n ^ ov;
      3'd6:    r = (n ^ ov) | z;
      default: r = 1'b1;
    endcase
    return r ^ inv;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic emit(input logic [31:0] w);
    prog.push_back(w);
  endtask

  task automatic loadConst(input logic [3:0] r, input logic [31:0] val);
    emit(regIns(1'b1, 1'b1, 1'b0, r, 4'd0, OpMov, val[31:16]));
    emit(regIns(1'b1, 1'b0, 1'b0, r, r, OpIor, val[15:0]));
  endtask

  task automatic beginProgram();
    prog.delete();
    expQ.delete();
    emit(regIns(1'b1, 1'b0, 1'b0, 4'd0, 4'd0, OpMov, 16'h0000));  // R0 base
    emit(regIns(1'b1, 1'b0, 1'b0, 4'd4, 4'd0, OpMov, 16'h0001));  // R4 marker
  endtask

  task automatic endProgram();
    emit(memIns(1'b1, 1'b0, 4'd0, 4'd0, 20'h00FFC));
    emit(brIns(1'b1, 1'b0, 1'b0, CcT, 22'h3FFFFF));  // Spin in place
  endtask

  task automatic runProgram(input logic stalls);
    int start;
    int cycles;
    for (int i = 0; i < 1024; i++) begin
      image[i[9:0]] = (i < prog.size()) ? prog[i] : fillWord(i);
    end
    @(posedge clk);
    rst     <= 1'b1;
    stallOn <= stalls;
    loadReq <= 1'b1;
    @(posedge clk);
    loadReq <= 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    start  = doneCount;
    cycles = 0;
    while (doneCount == start && cycles < 20000) begin
      @(posedge clk);
      cycles++;
    end
    if (doneCount == start) begin
      $display("Timeout: program of test %0d never reached its completion store", testNum);
      $display("Testbench failed");
      $finish;
    end else begin
      repeat (2) @(posedge clk);
      stallOn <= 1'b0;
    end
  endtask

  task automatic checkResults();
    for (int k = 0; k < expQ.size(); k++) begin
      checkValue($sformatf("mem[%0h]", 16'h300 + k), mem[10'h300 + k[9:0]], expQ[k]);
    end
  endtask

  task automatic finishTest(input string name, input int errBefore);
    if (errors == errBefore) begin
      $display("Test %0d %s: ok", testNum, name);
    end else begin
      failedTests++;
      $display("Test %0d %s: %0d mismatches", testNum, name, errors - errBefore);
    end
  endtask

  initial begin
    logic [3:0]  ops [11];
    logic [31:0] a, b;
    logic [15:0] imm;
    logic [63:0] p;
    logic [7:0]  lanes [4];
    logic        vb;
    int          e;
    int          x;
    rst = 1'b1;
    ops = '{OpMov, OpMov, OpAnd, OpAnn, OpIor, OpXor, OpAdd, OpSub, OpLsl, OpAsr, OpRor};

    testNum = 1;
    e = errors;
    beginProgram();
    for (int i = 0; i < 20; i++) begin
      a   = $random(seed);
      b   = $random(seed);
      imm = 16'($random(seed));
      vb  = 1'($random(seed));
      loadConst(4'd1, a);
      loadConst(4'd2, b);
      if (i % 11 < 2) begin  // MOV immediate, low then high half
        emit(regIns(1'b1, i % 11 == 1, vb, 4'd3, 4'd0, OpMov, imm));
        expQ.push_back(refExec(OpMov, 1'b1, i % 11 == 1, vb, a, b, imm));
      end else begin
        emit(regIns(1'b0, 1'b0, 1'b0, 4'd3, 4'd1, ops[i % 11], 16'h0002));
        expQ.push_back(refExec(ops[i % 11], 1'b0, 1'b0, 1'b0, a, b, 16'h0));
      end
      emit(memIns(1'b1, 1'b0, 4'd3, 4'd0, 20'h00C00 + 20'(4 * i)));
    end
    endProgram();
    runProgram(1'b0);
    checkResults();
    finishTest("register operations", e);

    testNum = 2;
    e = errors;
    beginProgram();
    for (int i = 0; i < 8; i++) begin
      a = $random(seed);
      b = $random(seed);
      loadConst(4'd1, a);
      loadConst(4'd2, b);
      emit(regIns(1'b0, i >= 4, 1'b0, 4'd3, 4'd1, OpMul, 16'h0002));  // u set is unsigned
      emit(regIns(1'b0, 1'b1, 1'b0, 4'd5, 4'd0, OpMov, 16'h0000));    // Read H
      emit(memIns(1'b1, 1'b0, 4'd3, 4'd0, 20'h00C00 + 20'(8 * i)));
      emit(memIns(1'b1, 1'b0, 4'd5, 4'd0, 20'h00C04 + 20'(8 * i)));
      p = refMul(i < 4, a, b);
      expQ.push_back(p[31:0]);
      expQ.push_back(p[63:32]);
    end
    endProgram();
    runProgram(1'b0);
    checkResults();
    finishTest("multiply", e);

    testNum = 3;
    e = errors;
    beginProgram();
    for (int i = 0; i < 16; i++) begin
      a = $random(seed);
      b = (i % 5 == 0) ? a : $random(seed);
      loadConst(4'd1, a);
      loadConst(4'd2, b);
      emit(regIns(1'b0, 1'b0, 1'b0, 4'd3, 4'd1, OpSub, 16'h0002));
      emit(brIns(1'b1, 1'b0, i[0], 3'(i / 2), 22'd1));  // Taken skips the marker
      emit(memIns(1'b1, 1'b0, 4'd4, 4'd0, 20'h00C00 + 20'(4 * i)));
      expQ.push_back(refCond(i[0], 3'(i / 2), a, b) ? fillWord(12'h300 + i) : 32'h1);
    end
    endProgram();
    runProgram(1'b0);
    checkResults();
    finishTest("conditional branches", e);

    testNum = 4;
    e = errors;
    beginProgram();
    for (int k = 0; k < 4; k++) begin
      a = $random(seed);
      lanes[k] = a[7:0];
      loadConst(4'd1, a);
      emit(memIns(1'b1, 1'b1, 4'd1, 4'd0, 20'h00900 + 20'(k)));
    end
    emit(memIns(1'b0, 1'b0, 4'd2, 4'd0, 20'h00900));
    emit(memIns(1'b1, 1'b0, 4'd2, 4'd0, 20'h00C00));
    expQ.push_back({lanes[3], lanes[2], lanes[1], lanes[0]});
    for (int k = 0; k < 4; k++) begin
      emit(memIns(1'b0, 1'b1, 4'd3, 4'd0, 20'h00900 + 20'(k)));
      emit(memIns(1'b1, 1'b0, 4'd3, 4'd0, 20'h00C04 + 20'(4 * k)));
      expQ.push_back({24'h0, lanes[k]});
    end
    endProgram();
    runProgram(1'b0);
    checkResults();
    checkValue("mem[240]", mem[10'h240], {lanes[3], lanes[2], lanes[1], lanes[0]});
    finishTest("byte lanes", e);

    testNum = 5;
    e = errors;
    beginProgram();
    x = prog.size();
    emit(brIns(1'b1, 1'b1, 1'b0, CcT, 22'd3));                      // BL to subroutine
    emit(regIns(1'b1, 1'b0, 1'b0, 4'd6, 4'd0, OpMov, 16'h0007));    // Return point
    emit(memIns(1'b1, 1'b0, 4'd6, 4'd0, 20'h00C04));
    emit(brIns(1'b1, 1'b0, 1'b0, CcT, 22'd2));
    emit(memIns(1'b1, 1'b0, 4'd15, 4'd0, 20'h00C00));               // Subroutine
    emit(brIns(1'b0, 1'b0, 1'b0, CcT, 22'd15));                     // Return via R15
    endProgram();
    expQ.push_back(32'((x + 1) * 4));
    expQ.push_back(32'h7);
    runProgram(1'b0);
    checkResults();
    finishTest("branch and link", e);

    testNum = 6;
    e = errors;
    beginProgram();
    for (int j = 0; j < 6; j++) begin
      a = $random(seed);
      loadConst(4'd1, a);
      emit(memIns(1'b1, 1'b0, 4'd1, 4'd0, 20'h00880 + 20'(8 * j)));
      emit(memIns(1'b1, 1'b1, 4'd1, 4'd0, 20'h00884 + 20'(8 * j + j % 4)));
      emit(memIns(1'b0, 1'b0, 4'd2, 4'd0, 20'h00880 + 20'(8 * j)));
      emit(memIns(1'b0, 1'b1, 4'd3, 4'd0, 20'h00884 + 20'(8 * j + j % 4)));
      emit(regIns(1'b0, 1'b0, 1'b0, 4'd5, 4'd2, OpAdd, 16'h0003));
      emit(memIns(1'b1, 1'b0, 4'd5, 4'd0, 20'h00C00 + 20'(4 * j)));
      expQ.push_back(refExec(OpAdd, 1'b0, 1'b0, 1'b0, a, {24'h0, a[7:0]}, 16'h0));
    end
    endProgram();
    runProgram(1'b0);
    checkResults();
    for (int i = 0; i < 1024; i++) begin
      snap[i[9:0]] = mem[i[9:0]];
    end
    runProgram(1'b1);
    for (int i = 0; i < 1024; i++) begin
      checkValue($sformatf("mem[%0h]", i), mem[i[9:0]], snap[i[9:0]]);
    end
    finishTest("stalled memory access", e);

    $display("Tests: %0d run, %0d failed; checks: %0d, errors: %0d",
             testNum, failedTests, checks, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* source/risc5Core.sv */
`timescale 1ns/1ps
`default_nettype none

module risc5Core import risc5Pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  logic        stallX,
  input  logic [31:0] inbus,
  input  logic [31:0] codebus,
  output logic [23:0] adr,
  output logic        rd,
  output logic        wr,
  output logic        ben,
  output logic [31:0] outbus
);

  logic [21:0] pc;
  logic [31:0] ir;
  logic        stall1;     // Second cycle of a load or store
  decodedInsn  dec;
  memRequest   req;
  logic [21:0] nxpc;
  logic [21:0] pcmux;
  logic        stall, stallL, stallM;
  logic        mulRun, taken, cond, regWrite;
  logic [31:0] regA, regB, c0, c1, ldData;
  logic [63:0] product;

  risc5Decode decodeU (.ins(ir), .dec(dec));

  assign mulRun = dec.isReg & (dec.op == OpMul);

  risc5Multiplier mulU (
    .clk(clk), .rst(rst), .run(mulRun), .u(~dec.u),  // Instruction u bit means unsigned
    .x(regB), .y(c1), .stall(stallM), .z(product)
  );

  risc5Execute execU (
    .clk(clk), .rst(rst), .dec(dec), .regWrite(regWrite), .ldData(ldData),
    .product(product), .linkPc(nxpc), .regA(regA), .regB(regB), .c0(c0), .c1(c1),
    .aluRes(), .cond(cond)
  );

  // Data cycle; the reset term keeps the restart fetch at StartAdr
  assign stallL = (dec.isLdr | dec.isStr) & ~stall1 & ~rst;
  assign stall  = stallL | stallM | stallX;
  assign nxpc   = pc + 22'd1;
  assign taken  = dec.isBr & cond;

  always_comb begin
    if (rst) begin
      pcmux = StartAdr;
    end else if (stall) begin
      pcmux = pc;
    end else if (taken && dec.u) begin
      pcmux = nxpc + dec.disp;
    end else if (taken) begin
      pcmux = c0[23:2];  // Branch through register
    end else begin
      pcmux = nxpc;
    end
  end

  assign regWrite = (dec.isReg & ~stall) |
                    (dec.isLdr & stallL & ~stallX) |
                    (taken & dec.v & ~stallX);  // BL writes R15

  assign req.addr   = stallL ? regB[23:0] + {{4{dec.off[19]}}, dec.off} : {pcmux, 2'b00};
  assign req.read   = dec.isLdr & stallL & ~stallX;
  assign req.write  = dec.isStr & stallL & ~stallX;
  assign req.byteEn = dec.v & stallL & ~stallX;
  assign req.data   = regA;

  risc5MemLanes lanesU (
    .req(req), .inbus(inbus), .adr(adr), .rd(rd), .wr(wr), .ben(ben),
    .outbus(outbus), .ldData(ldData)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      pc     <= StartAdr;
      ir     <= codebus;   // Word at StartAdr
      stall1 <= 1'b0;
    end else begin
      pc <= pcmux;
      if (!stall) begin
        ir <= codebus;
      end
      if (!stallX) begin
        stall1 <= stallL;
      end
    end
  end

endmodule

`default_nettype wire

/* source/risc5MemLanes.sv */
`timescale 1ns/1ps
`default_nettype none

module risc5MemLanes import risc5Pkg::*; (
  input  memRequest   req,
  input  logic [31:0] inbus,
  output logic [23:0] adr,
  output logic        rd,
  output logic        wr,
  output logic        ben,
  output logic [31:0] outbus,
  output logic [31:0] ldData
);

  logic [1:0] lane;
  logic [7:0] ldByte;

  assign adr  = req.addr;
  assign rd   = req.read;
  assign wr   = req.write;
  assign ben  = req.byteEn;
  assign lane = req.addr[1:0];

  // Byte loads come back zero-extended
  assign ldByte = inbus[{lane, 3'b000} +: 8];
  assign ldData = req.byteEn ? {24'b0, ldByte} : inbus;

  always_comb begin
    outbus = req.data;
    if (req.byteEn) begin
      outbus[{lane, 3'b000} +: 8] = req.data[7:0];  // Low byte into its lane
    end
  end

  // Read and write come from different instruction classes in the core
  always_comb begin
    assert (!(rd && wr))
      else $error("risc5MemLanes: rd and wr asserted together at %h", adr);
  end

endmodule

`default_nettype wire

/* source/risc5Execute.sv */
`timescale 1ns/1ps
`default_nettype none

module risc5Execute import risc5Pkg::*; (
  input  logic        clk,
  input  logic        rst,
  input  decodedInsn  dec,
  input  logic        regWrite,
  input  logic [31:0] ldData,
  input  logic [63:0] product,
  input  logic [21:0] linkPc,
  output logic [31:0] regA,
  output logic [31:0] regB,
  output logic [31:0] c0,
  output logic [31:0] c1,
  output logic [31:0] aluRes,
  output logic        cond
);

  logic [31:0] regs [16];
  logic [31:0] h;           // High word of the last MUL
  logic        n, z, c, ov;
  logic [3:0]  ira0;
  logic [4:0]  shamt;
  logic [63:0] rorPair;
  logic        cin;
  logic [32:0] sum;
  logic [32:0] diff;
  logic        signA, signB, signC;
  logic        isAdd, isSub;
  logic [31:0] regMux;
  logic        lt;
  logic        condRaw;

  assign ira0 = dec.isBr ? 4'd15 : dec.ira;  // Link register for BL
  assign regA = regs[ira0];
  assign regB = regs[dec.irb];
  assign c0   = regs[dec.irc];
  assign c1   = dec.q ? {{16{dec.v}}, dec.imm} : c0;

  assign shamt   = c1[4:0];
  assign rorPair = {regB, regB} >> shamt;
  assign cin     = dec.u & c;  // Carry variants of ADD and SUB
  assign sum     = {1'b0, regB} + {1'b0, c1} + {32'b0, cin};
  assign diff    = {1'b0, regB} - {1'b0, c1} - {32'b0, cin};

  always_comb begin
    case (dec.op)
      OpMov: begin
        if (dec.q) begin
          aluRes = dec.u ? {dec.imm, 16'b0} : {{16{dec.v}}, dec.imm};
        end else if (!dec.u) begin
          aluRes = c0;
        end else if (!dec.v) begin
          aluRes = h;
        end else begin
          aluRes = {n, z, c, ov, 20'b0, CoreId};  // Flag word
        end
      end
      OpLsl:   aluRes = regB << shamt;
      OpAsr:   aluRes = $signed(regB) >>> shamt;
      OpRor:   aluRes = rorPair[31:0];
      OpAnd:   aluRes = regB & c1;
      OpAnn:   aluRes = regB & ~c1;
      OpIor:   aluRes = regB | c1;
      OpXor:   aluRes = regB ^ c1;
      OpAdd:   aluRes = sum[31:0];
      OpSub:   aluRes = diff[31:0];
      OpMul:   aluRes = product[31:0];
      default: aluRes = 32'b0;
    endcase
  end

  assign regMux = dec.isLdr ? ldData :
                  (dec.isBr & dec.v) ? {8'b0, linkPc, 2'b00} : aluRes;

  assign isAdd = regWrite & dec.isReg & (dec.op == OpAdd);
  assign isSub = regWrite & dec.isReg & (dec.op == OpSub);
  assign signA = aluRes[31];
  assign signB = regB[31];
  assign signC = c1[31];

  always_ff @(posedge clk) begin
    if (regWrite) begin
      regs[ira0] <= regMux;
    end
    if (regWrite && dec.isReg && dec.op == OpMul) begin
      h <= product[63:32];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      n  <= 1'b0;
      z  <= 1'b0;
      c  <= 1'b0;
      ov <= 1'b0;
    end else begin
      if (regWrite) begin
        n <= regMux[31];
        z <= (regMux == 32'b0);
      end
      if (isAdd) begin
        c  <= sum[32];
        ov <= (signA & ~signB & ~signC) | (~signA & signB & signC);
      end else if (isSub) begin
        c  <= diff[32];  // Borrow
        ov <= (signA & ~signB & signC) | (~signA & signB & ~signC);
      end
    end
  end

  assign lt = n ^ ov;

  always_comb begin
    case (dec.cc)
      CcMi: condRaw = n;
      CcEq: condRaw = z;
      CcCs: condRaw = c;
      CcVs: condRaw = ov;
      CcLs: condRaw = c | z;
      CcLt: condRaw = lt;
      CcLe: condRaw = lt | z;
      CcT:  condRaw = 1'b1;
    endcase
  end

  assign cond = dec.ira[3] ^ condRaw;  // Bit 27 inverts

endmodule

`default_nettype wire

/* source/risc5Multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module risc5Multiplier (
  input  logic        clk,
  input  logic        rst,
  input  logic        run,
  input  logic        u,      // Signed operands
  input  logic [31:0] x,
  input  logic [31:0] y,
  output logic        stall,
  output logic [63:0] z
);

  logic [4:0]  count;
  logic [63:0] acc;
  logic [63:0] cur;
  logic [31:0] addend;
  logic [32:0] hiExt;
  logic [32:0] step;
  logic        lastStep;

  assign cur      = (count == 5'd0) ? {32'b0, x} : acc;  // First step starts from x
  assign lastStep = (count == 5'd31);
  assign addend   = cur[0] ? y : 32'b0;
  assign hiExt    = u ? {cur[63], cur[63:32]} : {1'b0, cur[63:32]};

  // Bit 31 of a signed multiplier carries negative weight
  always_comb begin
    if (u && lastStep) begin
      step = hiExt - {addend[31], addend};
    end else if (u) begin
      step = hiExt + {addend[31], addend};
    end else begin
      step = hiExt + {1'b0, addend};
    end
  end

  assign z     = {step, cur[31:1]};  // Final product during the last step
  assign stall = run & ~lastStep;

  always_ff @(posedge clk) begin
    if (rst) begin
      count <= 5'd0;
    end else if (run) begin
      count <= count + 5'd1;  // Wraps for a back-to-back MUL
    end else begin
      count <= 5'd0;
    end
  end

  always_ff @(posedge clk) begin
    acc <= z;
  end

  // A rising stall always ends within the 32-step window
  assert property (@(posedge clk) disable iff (rst) $rose(stall) |-> ##31 !stall);

endmodule

`default_nettype wire

/* source/risc5Decode.sv */
`timescale 1ns/1ps
`default_nettype none

module risc5Decode import risc5Pkg::*; (
  input  logic [31:0] ins,
  output decodedInsn  dec
);

  // Format bits
  assign dec.p = ins[31];
  assign dec.q = ins[30];
  assign dec.u = ins[29];
  assign dec.v = ins[28];

  // Register and operation fields
  assign dec.ira = ins[27:24];
  assign dec.irb = ins[23:20];
  assign dec.irc = ins[3:0];
  assign dec.op  = ins[19:16];
  assign dec.cc  = ins[26:24];  // Overlaps ira in branch format

  // Constants, one per format
  assign dec.imm  = ins[15:0];
  assign dec.off  = ins[19:0];
  assign dec.disp = ins[21:0];

  // Unimplemented opcodes 11 to 15 leave isReg low and write nothing
  assign dec.isReg = ~dec.p & (dec.op <= OpMul);
  assign dec.isLdr = dec.p & ~dec.q & ~dec.u;
  assign dec.isStr = dec.p & ~dec.q & dec.u;
  assign dec.isBr  = dec.p & dec.q;

  // The core relies on at most one of these selecting stall and write paths
  always_comb begin
    assert ($onehot0({dec.isLdr, dec.isStr, dec.isBr}))
      else $error("risc5Decode: overlapping instruction classes for %h", ins);
  end

endmodule

`default_nettype wire

/* source/risc5Pkg.sv */
`default_nettype none

package risc5Pkg;

  // Register instruction opcodes, ins[19:16]
  localparam logic [3:0] OpMov = 4'd0;
  localparam logic [3:0] OpLsl = 4'd1;
  localparam logic [3:0] OpAsr = 4'd2;
  localparam logic [3:0] OpRor = 4'd3;
  localparam logic [3:0] OpAnd = 4'd4;
  localparam logic [3:0] OpAnn = 4'd5;
  localparam logic [3:0] OpIor = 4'd6;
  localparam logic [3:0] OpXor = 4'd7;
  localparam logic [3:0] OpAdd = 4'd8;
  localparam logic [3:0] OpSub = 4'd9;
  localparam logic [3:0] OpMul = 4'd10;  // Codes above this retire as no-ops

  // Branch conditions, ins[26:24], inverted by ins[27]
  localparam logic [2:0] CcMi = 3'd0;  // N set
  localparam logic [2:0] CcEq = 3'd1;
  localparam logic [2:0] CcCs = 3'd2;
  localparam logic [2:0] CcVs = 3'd3;
  localparam logic [2:0] CcLs = 3'd4;  // C or Z
  localparam logic [2:0] CcLt = 3'd5;
  localparam logic [2:0] CcLe = 3'd6;
  localparam logic [2:0] CcT  = 3'd7;  // Always

  localparam logic [21:0] StartAdr = 22'h000000;  // Word address after reset
  localparam logic [7:0]  CoreId   = 8'h50;       // Low byte of the flag word

  typedef struct packed {
    logic        p;      // Memory or branch format
    logic        q;      // Immediate or branch
    logic        u;
    logic        v;
    logic [3:0]  ira;    // Destination, store source, or condition
    logic [3:0]  irb;
    logic [3:0]  irc;
    logic [3:0]  op;
    logic [2:0]  cc;
    logic [15:0] imm;
    logic [19:0] off;    // Load/store displacement
    logic [21:0] disp;   // Branch displacement in words
    logic        isReg;
    logic        isLdr;
    logic        isStr;
    logic        isBr;
  } decodedInsn;

  typedef struct packed {
    logic [23:0] addr;   // Byte address
    logic        read;
    logic        write;
    logic        byteEn;
    logic [31:0] data;   // Store data from register A
  } memRequest;

endpackage

`default_nettype wire
